//--- verilog/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

	localparam int xlen = 32;

	// RV32I major opcodes handled by the stage
	typedef enum logic [6:0] {
		opc_load   = 7'b0000011,
		opc_imm    = 7'b0010011,
		opc_auipc  = 7'b0010111,
		opc_store  = 7'b0100011,
		opc_reg    = 7'b0110011,
		opc_lui    = 7'b0110111,
		opc_branch = 7'b1100011
	} opcode_e;

	// Instruction class seen by the ALU controller
	typedef enum logic [3:0] {
		opt_load   = 4'b0000,
		opt_imm    = 4'b0010,
		opt_auipc  = 4'b0011,
		opt_store  = 4'b0100,
		opt_reg    = 4'b0110,
		opt_lui    = 4'b0111,
		opt_branch = 4'b1100,
		opt_none   = 4'b1111
	} alu_option_e;

	typedef enum logic [3:0] {
		op_add               = 4'b0000,
		op_sub               = 4'b0001,
		op_and               = 4'b0010,
		op_or                = 4'b0011,
		op_xor               = 4'b0100,
		op_u_low_eq          = 4'b0101,
		op_s_low_eq          = 4'b0110,
		op_u_high_eq         = 4'b0111,
		op_s_high_eq         = 4'b1000,
		op_u_lower           = 4'b1001,
		op_s_lower           = 4'b1010,
		op_u_higher          = 4'b1011,
		op_s_higher          = 4'b1100,
		op_shift_left        = 4'b1101,
		op_shift_right_logic = 4'b1110,
		op_shift_right_arit  = 4'b1111
	} alu_op_e;

	typedef struct packed {
		logic            valid;
		logic [6:0]      opcode;
		logic [2:0]      funct3;
		logic [6:0]      funct7;
		logic [4:0]      rd;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] rs1_val;
		logic [xlen-1:0] rs2_val;
		logic [xlen-1:0] imm;
	} exec_req_t;

	// Write-back packet leaving the stage
	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic            rd_we;
		logic            mem_read;
		logic            mem_write;
		logic [xlen-1:0] wb_value;
		logic [xlen-1:0] store_data;
		logic            branch_taken;
		logic [xlen-1:0] branch_target;
	} exec_res_t;

	typedef struct packed {
		alu_option_e alu_option;
		logic        a_sel_pc;
		logic        a_zero;
		logic        b_sel_imm;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		logic        is_branch;
	} ctrl_t;

endpackage

`default_nettype wire

//--- verilog/main_control.sv
`timescale 1ns/1ps
`default_nettype none

module main_control (
	input  rv_exec_pkg::exec_req_t         req,
	output rv_exec_pkg::ctrl_t             ctrl,
	output logic [rv_exec_pkg::xlen-1:0]   operand_a,
	output logic [rv_exec_pkg::xlen-1:0]   operand_b
);

	always_comb begin
		// Unknown opcodes fall through as a no-op
		ctrl.alu_option = rv_exec_pkg::opt_none;
		ctrl.a_sel_pc   = 1'b0;
		ctrl.a_zero     = 1'b0;
		ctrl.b_sel_imm  = 1'b0;
		ctrl.reg_write  = 1'b0;
		ctrl.mem_read   = 1'b0;
		ctrl.mem_write  = 1'b0;
		ctrl.is_branch  = 1'b0;

		case (req.opcode)
			rv_exec_pkg::opc_load: begin
				ctrl.alu_option = rv_exec_pkg::opt_load;
				ctrl.b_sel_imm  = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
			end
			rv_exec_pkg::opc_imm: begin
				ctrl.alu_option = rv_exec_pkg::opt_imm;
				ctrl.b_sel_imm  = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			rv_exec_pkg::opc_auipc: begin
				ctrl.alu_option = rv_exec_pkg::opt_auipc;
				ctrl.a_sel_pc   = 1'b1;
				ctrl.b_sel_imm  = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			rv_exec_pkg::opc_store: begin
				ctrl.alu_option = rv_exec_pkg::opt_store;
				ctrl.b_sel_imm  = 1'b1;
				ctrl.mem_write  = 1'b1;
			end
			rv_exec_pkg::opc_reg: begin
				ctrl.alu_option = rv_exec_pkg::opt_reg;
				ctrl.reg_write  = 1'b1;
			end
			rv_exec_pkg::opc_lui: begin
				// Zero plus the upper immediate
				ctrl.alu_option = rv_exec_pkg::opt_lui;
				ctrl.a_zero     = 1'b1;
				ctrl.b_sel_imm  = 1'b1;
				ctrl.reg_write  = 1'b1;
			end
			rv_exec_pkg::opc_branch: begin
				ctrl.alu_option = rv_exec_pkg::opt_branch;
				ctrl.is_branch  = 1'b1;
			end
			default: ;
		endcase
	end

	// Operand muxes
	always_comb begin
		if (ctrl.a_sel_pc) begin
			operand_a = req.pc;
		end else if (ctrl.a_zero) begin
			operand_a = '0;
		end else begin
			operand_a = req.rs1_val;
		end
		operand_b = ctrl.b_sel_imm ? req.imm : req.rs2_val;
	end

endmodule

`default_nettype wire

//--- verilog/alu_controller.sv
`timescale 1ns/1ps
`default_nettype none

module alu_controller (
	input  rv_exec_pkg::alu_option_e alu_option,
	input  logic [2:0]               func_3_bits,
	input  logic [6:0]               func_7_bits,
	output rv_exec_pkg::alu_op_e     alu_operation
);

	// Set for SUB and for the arithmetic right shift
	logic alt_bit;

	assign alt_bit = func_7_bits[5];

	always_comb begin
		alu_operation = rv_exec_pkg::op_add;

		case (alu_option)
			// Address generation and upper immediates all add
			rv_exec_pkg::opt_load,
			rv_exec_pkg::opt_store,
			rv_exec_pkg::opt_lui,
			rv_exec_pkg::opt_auipc: begin
				alu_operation = rv_exec_pkg::op_add;
			end

			rv_exec_pkg::opt_imm,
			rv_exec_pkg::opt_reg: begin
				case (func_3_bits)
					3'b000: begin
						// ADDI has immediate bits here, only R-type can subtract
						if (alu_option == rv_exec_pkg::opt_reg && alt_bit) begin
							alu_operation = rv_exec_pkg::op_sub;
						end else begin
							alu_operation = rv_exec_pkg::op_add;
						end
					end
					3'b001: alu_operation = rv_exec_pkg::op_shift_left;
					3'b010: alu_operation = rv_exec_pkg::op_s_lower;
					3'b011: alu_operation = rv_exec_pkg::op_u_lower;
					3'b100: alu_operation = rv_exec_pkg::op_xor;
					3'b101: begin
						if (alt_bit) begin
							alu_operation = rv_exec_pkg::op_shift_right_arit;
						end else begin
							alu_operation = rv_exec_pkg::op_shift_right_logic;
						end
					end
					3'b110: alu_operation = rv_exec_pkg::op_or;
					3'b111: alu_operation = rv_exec_pkg::op_and;
					default: alu_operation = rv_exec_pkg::op_add;
				endcase
			end

			rv_exec_pkg::opt_branch: begin
				case (func_3_bits)
					// BEQ, zero difference means equal
					3'b000: alu_operation = rv_exec_pkg::op_sub;
					// BNE
					3'b001: alu_operation = rv_exec_pkg::op_xor;
					// BLT
					3'b100: alu_operation = rv_exec_pkg::op_s_lower;
					// BGE
					3'b101: alu_operation = rv_exec_pkg::op_s_high_eq;
					// BLTU
					3'b110: alu_operation = rv_exec_pkg::op_u_lower;
					// BGEU
					3'b111: alu_operation = rv_exec_pkg::op_u_high_eq;
					default: alu_operation = rv_exec_pkg::op_add;
				endcase
			end

			default: alu_operation = rv_exec_pkg::op_add;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  logic [rv_exec_pkg::xlen-1:0] operand_a,
	input  logic [rv_exec_pkg::xlen-1:0] operand_b,
	input  rv_exec_pkg::alu_op_e         alu_op,
	output logic [rv_exec_pkg::xlen-1:0] result
);

	logic signed [rv_exec_pkg::xlen-1:0] a_s;
	logic signed [rv_exec_pkg::xlen-1:0] b_s;
	logic [4:0]                          shamt;
	logic                                cmp;

	assign a_s   = operand_a;
	assign b_s   = operand_b;
	assign shamt = operand_b[4:0];

	// Comparison outcome, only meaningful for the compare ops
	always_comb begin
		case (alu_op)
			rv_exec_pkg::op_u_low_eq:  cmp = operand_a <= operand_b;
			rv_exec_pkg::op_s_low_eq:  cmp = a_s <= b_s;
			rv_exec_pkg::op_u_high_eq: cmp = operand_a >= operand_b;
			rv_exec_pkg::op_s_high_eq: cmp = a_s >= b_s;
			rv_exec_pkg::op_u_lower:   cmp = operand_a < operand_b;
			rv_exec_pkg::op_s_lower:   cmp = a_s < b_s;
			rv_exec_pkg::op_u_higher:  cmp = operand_a > operand_b;
			rv_exec_pkg::op_s_higher:  cmp = a_s > b_s;
			default:                   cmp = 1'b0;
		endcase
	end

	always_comb begin
		case (alu_op)
			rv_exec_pkg::op_add: result = operand_a + operand_b;
			rv_exec_pkg::op_sub: result = operand_a - operand_b;
			rv_exec_pkg::op_and: result = operand_a & operand_b;
			rv_exec_pkg::op_or:  result = operand_a | operand_b;
			rv_exec_pkg::op_xor: result = operand_a ^ operand_b;

			rv_exec_pkg::op_u_low_eq,
			rv_exec_pkg::op_s_low_eq,
			rv_exec_pkg::op_u_high_eq,
			rv_exec_pkg::op_s_high_eq,
			rv_exec_pkg::op_u_lower,
			rv_exec_pkg::op_s_lower,
			rv_exec_pkg::op_u_higher,
			rv_exec_pkg::op_s_higher: begin
				result = {{(rv_exec_pkg::xlen-1){1'b0}}, cmp};
			end

			rv_exec_pkg::op_shift_left:        result = operand_a << shamt;
			rv_exec_pkg::op_shift_right_logic: result = operand_a >> shamt;
			// Sign bit fills from the left
			rv_exec_pkg::op_shift_right_arit:  result = a_s >>> shamt;
			default:                           result = operand_a + operand_b;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
	input  logic                         is_branch,
	input  rv_exec_pkg::alu_op_e         alu_op,
	input  logic [rv_exec_pkg::xlen-1:0] result,
	input  logic [rv_exec_pkg::xlen-1:0] pc,
	input  logic [rv_exec_pkg::xlen-1:0] imm,
	output logic                         taken,
	output logic [rv_exec_pkg::xlen-1:0] target
);

	always_comb begin
		taken = 1'b0;
		if (is_branch) begin
			case (alu_op)
				// BEQ
				rv_exec_pkg::op_sub: taken = (result == '0);
				// BNE
				rv_exec_pkg::op_xor: taken = (result != '0);
				// Compare ops leave the answer in bit 0
				rv_exec_pkg::op_s_lower,
				rv_exec_pkg::op_s_high_eq,
				rv_exec_pkg::op_u_lower,
				rv_exec_pkg::op_u_high_eq: taken = result[0];
				default: taken = 1'b0;
			endcase
		end
	end

	// PC-relative target, imm already sign extended by decode
	assign target = pc + imm;

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         valid,
	input  rv_exec_pkg::ctrl_t           ctrl,
	input  logic [4:0]                   rd,
	input  logic [rv_exec_pkg::xlen-1:0] result,
	input  logic [rv_exec_pkg::xlen-1:0] store_data,
	input  logic                         taken,
	input  logic [rv_exec_pkg::xlen-1:0] target,
	output rv_exec_pkg::exec_res_t       res
);

	// x0 is hardwired, never write it
	logic rd_nonzero;

	assign rd_nonzero = (rd != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			res <= '0;
		end else begin
			res.valid         <= valid;
			res.rd            <= rd;
			res.rd_we         <= valid & ctrl.reg_write & rd_nonzero;
			res.mem_read      <= valid & ctrl.mem_read;
			res.mem_write     <= valid & ctrl.mem_write;
			res.wb_value      <= result;
			res.store_data    <= store_data;
			res.branch_taken  <= valid & taken;
			res.branch_target <= target;
		end
	end

endmodule

`default_nettype wire

//--- verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  logic                   clk,
	input  logic                   reset,
	input  rv_exec_pkg::exec_req_t req,
	output rv_exec_pkg::exec_res_t res
);

	rv_exec_pkg::ctrl_t           ctrl;
	rv_exec_pkg::alu_op_e         alu_op;
	logic [rv_exec_pkg::xlen-1:0] operand_a;
	logic [rv_exec_pkg::xlen-1:0] operand_b;
	logic [rv_exec_pkg::xlen-1:0] result;
	logic                         taken;
	logic [rv_exec_pkg::xlen-1:0] target;

	main_control u_main_control (
		.req       (req),
		.ctrl      (ctrl),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	alu_controller u_alu_controller (
		.alu_option    (ctrl.alu_option),
		.func_3_bits   (req.funct3),
		.func_7_bits   (req.funct7),
		.alu_operation (alu_op)
	);

	alu u_alu (
		.operand_a (operand_a),
		.operand_b (operand_b),
		.alu_op    (alu_op),
		.result    (result)
	);

	branch_resolve u_branch_resolve (
		.is_branch (ctrl.is_branch),
		.alu_op    (alu_op),
		.result    (result),
		.pc        (req.pc),
		.imm       (req.imm),
		.taken     (taken),
		.target    (target)
	);

	// Single register stage, one cycle latency
	result_stage u_result_stage (
		.clk        (clk),
		.reset      (reset),
		.valid      (req.valid),
		.ctrl       (ctrl),
		.rd         (req.rd),
		.result     (result),
		.store_data (req.rs2_val),
		.taken      (taken),
		.target     (target),
		.res        (res)
	);

endmodule

`default_nettype wire

//--- sim/tb_exec_model.svh
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// RV32I arithmetic for OP and OP-IMM
function automatic logic [31:0] arith_ref(
	input logic [2:0]  funct3,
	input logic        is_reg,
	input logic        alt,
	input logic [31:0] a,
	input logic [31:0] b
);
	logic signed [31:0] sa;
	sa = a;
	case (funct3)
		3'd0: return (is_reg && alt) ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return {31'd0, sa < $signed(b)};
		3'd3: return {31'd0, a < b};
		3'd4: return a ^ b;
		3'd5: begin
			if (alt) begin
				return sa >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

// Architectural branch condition
function automatic logic taken_ref(input logic [2:0] funct3, input logic [31:0] a,
	input logic [31:0] b);
	case (funct3)
		3'd0: return a == b;
		3'd1: return a != b;
		3'd4: return $signed(a) < $signed(b);
		3'd5: return $signed(a) >= $signed(b);
		3'd6: return a < b;
		3'd7: return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic rv_exec_pkg::exec_res_t expected_packet(input rv_exec_pkg::exec_req_t r);
	rv_exec_pkg::exec_res_t p;
	logic [31:0]            v;
	logic                   writes;
	logic                   taken;
	writes = 1'b1;
	taken  = 1'b0;
	case (r.opcode)
		rv_exec_pkg::opc_lui:   v = r.imm;
		rv_exec_pkg::opc_auipc: v = r.pc + r.imm;
		rv_exec_pkg::opc_load:  v = r.rs1_val + r.imm;
		rv_exec_pkg::opc_store: begin
			v      = r.rs1_val + r.imm;
			writes = 1'b0;
		end
		rv_exec_pkg::opc_imm: v = arith_ref(r.funct3, 1'b0, r.funct7[5], r.rs1_val, r.imm);
		rv_exec_pkg::opc_reg: v = arith_ref(r.funct3, 1'b1, r.funct7[5], r.rs1_val, r.rs2_val);
		rv_exec_pkg::opc_branch: begin
			taken  = taken_ref(r.funct3, r.rs1_val, r.rs2_val);
			writes = 1'b0;
			// BEQ subtracts and BNE xors, the others leave the compare bit
			case (r.funct3)
				3'd0: v = r.rs1_val - r.rs2_val;
				3'd1: v = r.rs1_val ^ r.rs2_val;
				3'd2, 3'd3: v = r.rs1_val + r.rs2_val;
				default: v = {31'd0, taken};
			endcase
		end
		default: begin
			v      = r.rs1_val + r.rs2_val;
			writes = 1'b0;
		end
	endcase
	p.valid         = r.valid;
	p.rd            = r.rd;
	p.rd_we         = r.valid && writes && (r.rd != 5'd0);
	p.mem_read      = r.valid && (r.opcode == rv_exec_pkg::opc_load);
	p.mem_write     = r.valid && (r.opcode == rv_exec_pkg::opc_store);
	p.wb_value      = v;
	p.store_data    = r.rs2_val;
	p.branch_taken  = r.valid && taken;
	p.branch_target = r.pc + r.imm;
	return p;
endfunction

`endif

//--- sim/tb_rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_execute;

	// About 150 directed requests, the random run, reset and drain
	localparam int n_random   = 2000;
	localparam int max_cycles = 3000;

	localparam logic [31:0] corner_a [6] = '{32'h7fffffff, 32'hffffffff, 32'h80000000,
		32'h00000001, 32'h12345678, 32'h80000000};
	localparam logic [31:0] corner_b [6] = '{32'h00000001, 32'h00000001, 32'h0000001f,
		32'hffffffff, 32'h00000000, 32'h7fffffff};
	localparam logic [31:0] branch_a [3] = '{32'h5, 32'hffffffff, 32'h1};
	localparam logic [31:0] branch_b [3] = '{32'h5, 32'h1, 32'hffffffff};
	localparam logic [2:0]  branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	localparam logic [6:0]  opcodes [7] = '{rv_exec_pkg::opc_load, rv_exec_pkg::opc_imm,
		rv_exec_pkg::opc_auipc, rv_exec_pkg::opc_store, rv_exec_pkg::opc_reg,
		rv_exec_pkg::opc_lui, rv_exec_pkg::opc_branch};

	logic                   clk;
	logic                   reset;
	rv_exec_pkg::exec_req_t req;
	rv_exec_pkg::exec_res_t res;
	rv_exec_pkg::exec_req_t prev_req;
	logic                   prev_reset;
	rv_exec_pkg::exec_res_t expected;
	int                     cycle_count = 0;
	int                     sent_count = 0;
	int                     seen_count = 0;
	logic [31:0]            next_pc = 32'h00000100;

	`include "tb_exec_model.svh"

	rv_execute u_dut (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.res   (res)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		report_failure();
	endtask

	task automatic drive(input rv_exec_pkg::exec_req_t r);
		@(posedge clk);
		req <= r;
		if (r.valid) begin
			sent_count++;
		end
	endtask

	task automatic send_op(
		input logic [6:0]  opcode,
		input logic [2:0]  funct3,
		input logic [6:0]  funct7,
		input logic [4:0]  rd,
		input logic [31:0] a,
		input logic [31:0] b,
		input logic [31:0] imm
	);
		rv_exec_pkg::exec_req_t r;
		r = '{1'b1, opcode, funct3, funct7, rd, next_pc, a, b, imm};
		next_pc += 32'd4;
		drive(r);
	endtask

	// Boundary values now and then
	function automatic logic [31:0] pick_word();
		if ($urandom_range(0, 3) == 0) begin
			return corner_a[$urandom_range(0, 5)];
		end
		return $urandom;
	endfunction

	// Request seen by the DUT one edge back, plus the timeout
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		prev_req    <= req;
		prev_reset  <= reset;
		if (res.valid) begin
			seen_count <= seen_count + 1;
		end
		if (cycle_count >= max_cycles) begin
			$display("The run timed out after %0d cycles", cycle_count);
			report_failure();
		end
	end

	always_comb expected = expected_packet(prev_req);

	assert property (@(posedge clk) cycle_count > 0 && prev_reset |-> res == '0)
		else report_mismatch($sformatf("packet %h not cleared by reset", $sampled(res)));

	assert property (@(posedge clk) cycle_count > 0 && !prev_reset |-> res == expected)
		else report_mismatch($sformatf("opcode %b funct3 %0d: got %h, expected %h",
			$sampled(prev_req.opcode), $sampled(prev_req.funct3), $sampled(res),
			$sampled(expected)));

	assert property (@(posedge clk) cycle_count > 0 && !prev_reset && !prev_req.valid |->
		{res.valid, res.rd_we, res.mem_read, res.mem_write, res.branch_taken} == '0)
		else report_mismatch("flags raised for a request with valid low");

	assert property (@(posedge clk) cycle_count > 0 && prev_req.rd == 5'd0 |-> !res.rd_we)
		else report_mismatch("write enable raised for destination x0");

	initial begin
		rv_exec_pkg::exec_req_t r;
		void'($urandom(32'h1d5f));
		reset = 1'b1;
		req   = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Register then immediate sweep, rd cycles through x0
		for (int op = 0; op < 2; op++) begin
			for (int f3 = 0; f3 < 8; f3++) begin
				for (int alt = 0; alt < 2; alt++) begin
					if (alt == 0 || f3 == 0 || f3 == 5) begin
						for (int i = 0; i < 6; i++) begin
							send_op((op == 0) ? rv_exec_pkg::opc_reg : rv_exec_pkg::opc_imm,
								3'(f3), (alt != 0) ? 7'h20 : 7'h00, 5'(i),
								corner_a[i], corner_b[i], corner_b[i]);
						end
					end
				end
			end
		end
		send_op(rv_exec_pkg::opc_lui, 3'd0, 7'h00, 5'd3, 32'h5, 32'h6, 32'hfffff000);
		send_op(rv_exec_pkg::opc_lui, 3'd0, 7'h00, 5'd0, 32'h5, 32'h6, 32'h12345000);
		send_op(rv_exec_pkg::opc_auipc, 3'd0, 7'h00, 5'd4, 32'h5, 32'h6, 32'h80000000);
		send_op(rv_exec_pkg::opc_load, 3'd2, 7'h00, 5'd5, 32'h1000, 32'h6, 32'hfffffffc);
		send_op(rv_exec_pkg::opc_store, 3'd2, 7'h00, 5'd6, 32'h2000, 32'hcafe, 32'h8);
		// Each condition sees taken and not taken
		for (int k = 0; k < 6; k++) begin
			for (int i = 0; i < 3; i++) begin
				send_op(rv_exec_pkg::opc_branch, branch_f3[k], 7'h00, 5'd9,
					branch_a[i], branch_b[i], 32'hfffffff0);
			end
		end
		r = '{1'b0, rv_exec_pkg::opc_load, 3'd2, 7'h00, 5'd7, 32'h40, 32'h80, 32'h1, 32'h4};
		drive(r);

		for (int n = 0; n < n_random; n++) begin
			r.valid   = ($urandom_range(0, 7) != 0);
			r.opcode  = opcodes[$urandom_range(0, 6)];
			r.funct3  = 3'($urandom);
			r.funct7  = ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
			r.rd      = 5'($urandom);
			r.pc      = $urandom & 32'hfffffffc;
			r.rs1_val = pick_word();
			r.rs2_val = ($urandom_range(0, 7) == 0) ? r.rs1_val : pick_word();
			r.imm     = pick_word();
			// Branch funct3 010 and 011 are reserved
			if (r.opcode == rv_exec_pkg::opc_branch && !r.funct3[2]) begin
				r.funct3[1] = 1'b0;
			end
			drive(r);
		end

		r = '0;
		drive(r);
		repeat (2) @(posedge clk);
		if (seen_count == sent_count) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("Sent %0d valid requests but counted %0d results", sent_count, seen_count);
			report_failure();
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
verilog/rv_exec_pkg.sv
verilog/main_control.sv
verilog/alu_controller.sv
verilog/alu.sv
verilog/branch_resolve.sv
verilog/result_stage.sv
verilog/rv_execute.sv
sim/tb_rv_execute.sv

//--- Bender.yml
package:
  name: rv_execute

sources:
  - verilog/rv_exec_pkg.sv
  - verilog/main_control.sv
  - verilog/alu_controller.sv
  - verilog/alu.sv
  - verilog/branch_resolve.sv
  - verilog/result_stage.sv
  - verilog/rv_execute.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_rv_execute.sv
